//--- Bender.yml
package:
  name: mul_copro

sources:
  - design/mul_pkg.sv
  - design/mul_axil_wr.sv
  - design/mul_unit.sv
  - design/mul_axil_rd.sv
  - design/mul_copro_top.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_mul_copro.sv

//--- design/mul_axil_rd.sv
`timescale 1ns/1ns
`default_nettype none

module mul_axil_rd (
    input  wire                        clk_i,
    input  wire                        rstn_i,
    input  wire                        s_axil_arvalid_i,
    input  wire  [mul_pkg::AXI_AW-1:0] s_axil_araddr_i,
    input  wire                        s_axil_rready_i,
    input  wire                        request_i,      // New op, clears done
    input  wire                        done_tick_i,
    input  wire  [mul_pkg::XLEN-1:0]   result_i,
    output logic                       s_axil_arready_o,
    output logic                       s_axil_rvalid_o,
    output logic [mul_pkg::AXI_DW-1:0] s_axil_rdata_o,
    output logic [1:0]                 s_axil_rresp_o
);

    logic                        arready_q;
    logic                        rvalid_q;
    logic [mul_pkg::AXI_DW-1:0]  rdata_q;
    logic [1:0]                  rresp_q;
    logic                        rd_hs;
    logic                        done_q;      // Status done flag
    logic [mul_pkg::XLEN-1:0]    res_q;       // Captured product
    logic [mul_pkg::AXI_DW-1:0]  rd_word;
    logic [1:0]                  rd_resp;

    assign rd_hs = arready_q & s_axil_arvalid_i;

    // Read mux, operand and control offsets are write-only
    always_comb begin
        rd_word = '0;
        rd_resp = mul_pkg::RESP_OKAY;
        case (s_axil_araddr_i)
            mul_pkg::ADDR_STATUS: rd_word[mul_pkg::STAT_DONE_BIT] = done_q;
            mul_pkg::ADDR_RES_LO: rd_word = res_q[mul_pkg::AXI_DW-1:0];
            mul_pkg::ADDR_RES_HI: rd_word = res_q[mul_pkg::XLEN-1:mul_pkg::AXI_DW];
            default:              rd_resp = mul_pkg::RESP_SLVERR;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            done_q    <= 1'b0;
            res_q     <= '0;
            arready_q <= 1'b0;
            rvalid_q  <= 1'b0;
        end else begin
            if (done_tick_i) begin                 // Wins over a same-cycle MULW start
                res_q  <= result_i;
                done_q <= 1'b1;
            end else if (request_i) begin
                done_q <= 1'b0;
            end
            arready_q <= s_axil_arvalid_i & ~rvalid_q & ~arready_q;
            if (rd_hs)                rvalid_q <= 1'b1;
            else if (s_axil_rready_i) rvalid_q <= 1'b0;
        end
    end

    // R payload, loaded at the AR handshake only
    always_ff @(posedge clk_i) begin
        if (rd_hs) begin
            rdata_q <= rd_word;
            rresp_q <= rd_resp;
        end
    end

    assign s_axil_arready_o = arready_q;
    assign s_axil_rvalid_o  = rvalid_q;
    assign s_axil_rdata_o   = rdata_q;
    assign s_axil_rresp_o   = rresp_q;

    // Stalled R beat keeps its payload
    a_r_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (rvalid_q && !s_axil_rready_i) |=>
            (rvalid_q && $stable(rdata_q) && $stable(rresp_q)));

endmodule

`default_nettype wire

//--- design/mul_axil_wr.sv
`timescale 1ns/1ns
`default_nettype none

module mul_axil_wr (
    input  wire                            clk_i,
    input  wire                            rstn_i,
    input  wire                            s_axil_awvalid_i,
    input  wire  [mul_pkg::AXI_AW-1:0]     s_axil_awaddr_i,
    input  wire                            s_axil_wvalid_i,
    input  wire  [mul_pkg::AXI_DW-1:0]     s_axil_wdata_i,
    input  wire  [mul_pkg::AXI_DW/8-1:0]   s_axil_wstrb_i,
    input  wire                            s_axil_bready_i,
    input  wire                            stall_i,          // Multiplier busy
    output logic                           s_axil_awready_o,
    output logic                           s_axil_wready_o,
    output logic                           s_axil_bvalid_o,
    output logic [1:0]                     s_axil_bresp_o,
    output logic [mul_pkg::XLEN-1:0]       src1_o,
    output logic [mul_pkg::XLEN-1:0]       src2_o,
    output logic [2:0]                     func3_o,
    output logic                           int_32_o,
    output logic                           request_o         // One-cycle start
);

    logic                         ready_q;     // Joint AW/W ready pulse
    logic                         bvalid_q;
    logic [1:0]                   bresp_q;
    logic                         wr_hs;       // AW and W taken together
    logic                         wr_ok;       // Offset is writable
    logic                         ctrl_hit;
    logic                         start_req;
    logic                         request_q;
    logic [mul_pkg::XLEN-1:0]     src1_q;
    logic [mul_pkg::XLEN-1:0]     src2_q;
    logic [2:0]                   func3_q;
    logic                         int_32_q;

    // Byte-lane merge of a write into a 32-bit half
    function automatic logic [mul_pkg::AXI_DW-1:0] strb_merge(
        input logic [mul_pkg::AXI_DW-1:0]   old_w,
        input logic [mul_pkg::AXI_DW-1:0]   new_w,
        input logic [mul_pkg::AXI_DW/8-1:0] strb
    );
        logic [mul_pkg::AXI_DW-1:0] res;
        res = old_w;
        for (int b = 0; b < mul_pkg::AXI_DW/8; b++) begin
            if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

    assign wr_hs     = ready_q & s_axil_awvalid_i & s_axil_wvalid_i;
    assign ctrl_hit  = (s_axil_awaddr_i == mul_pkg::ADDR_CTRL);
    assign start_req = wr_hs & ctrl_hit & s_axil_wstrb_i[0]
                     & s_axil_wdata_i[mul_pkg::CTRL_START_BIT];

    always_comb begin
        case (s_axil_awaddr_i)
            mul_pkg::ADDR_SRC1_LO, mul_pkg::ADDR_SRC1_HI,
            mul_pkg::ADDR_SRC2_LO, mul_pkg::ADDR_SRC2_HI,
            mul_pkg::ADDR_CTRL: wr_ok = 1'b1;
            default:            wr_ok = 1'b0;  // Status, result, misaligned
        endcase
    end

    // Handshake, B response and start pulse
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ready_q   <= 1'b0;
            bvalid_q  <= 1'b0;
            bresp_q   <= mul_pkg::RESP_OKAY;
            request_q <= 1'b0;
            func3_q   <= mul_pkg::FUNC3_MUL;
            int_32_q  <= 1'b0;
        end else begin
            ready_q <= s_axil_awvalid_i & s_axil_wvalid_i & ~bvalid_q & ~ready_q;
            if (wr_hs) begin
                bvalid_q <= 1'b1;
                bresp_q  <= wr_ok ? mul_pkg::RESP_OKAY : mul_pkg::RESP_SLVERR;
            end else if (s_axil_bready_i) begin
                bvalid_q <= 1'b0;                  // Response taken
            end
            request_q <= start_req & ~stall_i;     // Start dropped while busy
            if (wr_hs && ctrl_hit && s_axil_wstrb_i[0]) begin
                func3_q  <= s_axil_wdata_i[mul_pkg::CTRL_FUNC3_LSB +: 3];
                int_32_q <= s_axil_wdata_i[mul_pkg::CTRL_WORD_BIT];
            end
        end
    end

    // Operand halves, byte strobed
    always_ff @(posedge clk_i) begin
        if (wr_hs) begin
            case (s_axil_awaddr_i)
                mul_pkg::ADDR_SRC1_LO: src1_q[mul_pkg::AXI_DW-1:0] <=
                    strb_merge(src1_q[mul_pkg::AXI_DW-1:0], s_axil_wdata_i, s_axil_wstrb_i);
                mul_pkg::ADDR_SRC1_HI: src1_q[mul_pkg::XLEN-1:mul_pkg::AXI_DW] <=
                    strb_merge(src1_q[mul_pkg::XLEN-1:mul_pkg::AXI_DW], s_axil_wdata_i,
                               s_axil_wstrb_i);
                mul_pkg::ADDR_SRC2_LO: src2_q[mul_pkg::AXI_DW-1:0] <=
                    strb_merge(src2_q[mul_pkg::AXI_DW-1:0], s_axil_wdata_i, s_axil_wstrb_i);
                mul_pkg::ADDR_SRC2_HI: src2_q[mul_pkg::XLEN-1:mul_pkg::AXI_DW] <=
                    strb_merge(src2_q[mul_pkg::XLEN-1:mul_pkg::AXI_DW], s_axil_wdata_i,
                               s_axil_wstrb_i);
                default: ;                         // Control handled above
            endcase
        end
    end

    assign s_axil_awready_o = ready_q;
    assign s_axil_wready_o  = ready_q;
    assign s_axil_bvalid_o  = bvalid_q;
    assign s_axil_bresp_o   = bresp_q;
    assign src1_o           = src1_q;
    assign src2_o           = src2_q;
    assign func3_o          = func3_q;
    assign int_32_o         = int_32_q;
    assign request_o        = request_q;

    // No new start in the second cycle of a 64-bit op
    a_no_start_in_flight: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (request_o && !int_32_o) |=> !request_o);

endmodule

`default_nettype wire

//--- design/mul_copro_top.sv
`timescale 1ns/1ns
`default_nettype none

module mul_copro_top (
    input  wire                          clk_i,
    input  wire                          rstn_i,
    // Write address and data
    input  wire                          s_axil_awvalid_i,
    output logic                         s_axil_awready_o,
    input  wire  [mul_pkg::AXI_AW-1:0]   s_axil_awaddr_i,
    input  wire                          s_axil_wvalid_i,
    output logic                         s_axil_wready_o,
    input  wire  [mul_pkg::AXI_DW-1:0]   s_axil_wdata_i,
    input  wire  [mul_pkg::AXI_DW/8-1:0] s_axil_wstrb_i,
    // Write response
    output logic                         s_axil_bvalid_o,
    input  wire                          s_axil_bready_i,
    output logic [1:0]                   s_axil_bresp_o,
    // Read address and data
    input  wire                          s_axil_arvalid_i,
    output logic                         s_axil_arready_o,
    input  wire  [mul_pkg::AXI_AW-1:0]   s_axil_araddr_i,
    output logic                         s_axil_rvalid_o,
    input  wire                          s_axil_rready_i,
    output logic [mul_pkg::AXI_DW-1:0]   s_axil_rdata_o,
    output logic [1:0]                   s_axil_rresp_o
);

    logic [mul_pkg::XLEN-1:0] src1;
    logic [mul_pkg::XLEN-1:0] src2;
    logic [2:0]               func3;
    logic                     int_32;
    logic                     request;    // Start pulse into the multiplier
    logic [mul_pkg::XLEN-1:0] result;
    logic                     stall;
    logic                     done_tick;

    mul_axil_wr u_wr (
        .clk_i, .rstn_i,
        .s_axil_awvalid_i, .s_axil_awaddr_i, .s_axil_wvalid_i,
        .s_axil_wdata_i, .s_axil_wstrb_i, .s_axil_bready_i,
        .stall_i          (stall),
        .s_axil_awready_o, .s_axil_wready_o, .s_axil_bvalid_o, .s_axil_bresp_o,
        .src1_o (src1), .src2_o (src2), .func3_o (func3), .int_32_o (int_32),
        .request_o        (request)
    );

    mul_unit u_mul (
        .clk_i, .rstn_i,
        .request_i (request), .func3_i (func3), .int_32_i (int_32),
        .src1_i (src1), .src2_i (src2),
        .result_o (result), .stall_o (stall), .done_tick_o (done_tick)
    );

    mul_axil_rd u_rd (
        .clk_i, .rstn_i,
        .s_axil_arvalid_i, .s_axil_araddr_i, .s_axil_rready_i,
        .request_i (request), .done_tick_i (done_tick), .result_i (result),
        .s_axil_arready_o, .s_axil_rvalid_o, .s_axil_rdata_o, .s_axil_rresp_o
    );

endmodule

`default_nettype wire

//--- design/mul_pkg.sv
`default_nettype none

package mul_pkg;

    // Datapath and bus widths
    localparam int XLEN   = 64;                 // Operand and result width
    localparam int AXI_DW = 32;                 // AXI4-Lite data width
    localparam int AXI_AW = 5;                  // Eight 32-bit registers

    // Register map, byte offsets
    localparam logic [AXI_AW-1:0] ADDR_SRC1_LO = 5'h00;
    localparam logic [AXI_AW-1:0] ADDR_SRC1_HI = 5'h04;
    localparam logic [AXI_AW-1:0] ADDR_SRC2_LO = 5'h08;
    localparam logic [AXI_AW-1:0] ADDR_SRC2_HI = 5'h0C;
    localparam logic [AXI_AW-1:0] ADDR_CTRL    = 5'h10;
    localparam logic [AXI_AW-1:0] ADDR_STATUS  = 5'h14;  // Read only
    localparam logic [AXI_AW-1:0] ADDR_RES_LO  = 5'h18;  // Read only
    localparam logic [AXI_AW-1:0] ADDR_RES_HI  = 5'h1C;  // Read only

    // Control word, all in byte 0
    localparam int CTRL_FUNC3_LSB = 0;          // func3 in bits 2..0
    localparam int CTRL_WORD_BIT  = 3;          // Selects MULW
    localparam int CTRL_START_BIT = 4;          // Self-clearing start

    // Status word
    localparam int STAT_DONE_BIT = 0;

    // M-extension func3 codes
    localparam logic [2:0] FUNC3_MUL    = 3'd0; // Low half, also MULW
    localparam logic [2:0] FUNC3_MULH   = 3'd1; // High half, signed x signed
    localparam logic [2:0] FUNC3_MULHSU = 3'd2; // High half, signed x unsigned
    localparam logic [2:0] FUNC3_MULHU  = 3'd3; // High half, unsigned x unsigned

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

//--- design/mul_unit.sv
`timescale 1ns/1ns
`default_nettype none

module mul_unit (
    input  wire                       clk_i,
    input  wire                       rstn_i,
    input  wire                       request_i,
    input  wire  [2:0]                func3_i,
    input  wire                       int_32_i,     // MULW
    input  wire  [mul_pkg::XLEN-1:0]  src1_i,       // Multiplicand
    input  wire  [mul_pkg::XLEN-1:0]  src2_i,       // Multiplier
    output logic [mul_pkg::XLEN-1:0]  result_o,
    output logic                      stall_o,      // 64-bit op in flight
    output logic                      done_tick_o   // Result valid this cycle
);

    logic                           same_sign;
    logic [mul_pkg::XLEN-1:0]       src1_def;     // Magnitudes
    logic [mul_pkg::XLEN-1:0]       src2_def;
    logic                           neg_def;      // Product must be negated
    logic                           state_q;      // 0 idle, 1 second cycle
    logic [3*mul_pkg::XLEN/2-1:0]   pp_lo_d;      // Multiplicand x low half
    logic [3*mul_pkg::XLEN/2-1:0]   pp_hi_d;      // Multiplicand x high half
    logic [3*mul_pkg::XLEN/2-1:0]   pp_lo_q;
    logic [3*mul_pkg::XLEN/2-1:0]   pp_hi_q;
    logic [2*mul_pkg::XLEN-1:0]     prod_128;
    logic [2*mul_pkg::XLEN-1:0]     prod_128_def;
    logic [mul_pkg::XLEN-1:0]       res_32_aux;
    logic [mul_pkg::XLEN-1:0]       res_32;
    logic [mul_pkg::XLEN-1:0]       res_64;

    // Word ops look at bit 31 for the sign
    assign same_sign = int_32_i ? ~(src1_i[31] ^ src2_i[31]) : ~(src1_i[63] ^ src2_i[63]);

    // Take magnitudes of signed negative sources
    always_comb begin
        case (func3_i)
            mul_pkg::FUNC3_MUL: begin
                src1_def = ((src1_i[63] & ~int_32_i) | (src1_i[31] & int_32_i)) ?
                           ~src1_i + 64'd1 : src1_i;
                src2_def = ((src2_i[63] & ~int_32_i) | (src2_i[31] & int_32_i)) ?
                           ~src2_i + 64'd1 : src2_i;
                neg_def  = ~same_sign;
            end
            mul_pkg::FUNC3_MULH: begin
                src1_def = src1_i[63] ? ~src1_i + 64'd1 : src1_i;
                src2_def = src2_i[63] ? ~src2_i + 64'd1 : src2_i;
                neg_def  = ~same_sign;
            end
            mul_pkg::FUNC3_MULHSU: begin
                src1_def = src1_i[63] ? ~src1_i + 64'd1 : src1_i;
                src2_def = src2_i;                 // Unsigned multiplier
                neg_def  = src1_i[63];
            end
            mul_pkg::FUNC3_MULHU: begin
                src1_def = src1_i;
                src2_def = src2_i;
                neg_def  = 1'b0;
            end
            default: begin                         // Division codes not served
                src1_def = '0;
                src2_def = '0;
                neg_def  = 1'b0;
            end
        endcase
    end

    // Split product, 64x32 each
    assign pp_lo_d = src1_def * src2_def[mul_pkg::XLEN/2-1:0];
    assign pp_hi_d = src1_def * src2_def[mul_pkg::XLEN-1:mul_pkg::XLEN/2];

    // MULW finishes from the low partial product alone
    assign res_32_aux = neg_def ? ~pp_lo_d[mul_pkg::XLEN-1:0] + 64'd1
                                : pp_lo_d[mul_pkg::XLEN-1:0];
    assign res_32     = {{32{res_32_aux[31]}}, res_32_aux[31:0]};

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) state_q <= 1'b0;
        else         state_q <= stall_o;           // Second cycle follows a stall
    end

    always_ff @(posedge clk_i) begin
        pp_lo_q <= pp_lo_d;
        pp_hi_q <= pp_hi_d;
    end

    // Idle: word ops done at once, 64-bit ops stall one cycle
    always_comb begin
        if (state_q) begin
            stall_o     = 1'b0;
            done_tick_o = 1'b1;
        end else begin
            stall_o     = request_i & ~int_32_i;
            done_tick_o = request_i & int_32_i;
        end
    end

    // Second cycle, recombine and fix the sign
    assign prod_128     = {32'd0, pp_lo_q} + {pp_hi_q, 32'd0};
    assign prod_128_def = neg_def ? ~prod_128 + 128'd1 : prod_128;

    always_comb begin
        if (func3_i == mul_pkg::FUNC3_MUL) res_64 = prod_128_def[mul_pkg::XLEN-1:0];
        else                               res_64 = prod_128_def[2*mul_pkg::XLEN-1:mul_pkg::XLEN];
    end

    assign result_o = done_tick_o ? (int_32_i ? res_32 : res_64) : '0;

    // A request in the second cycle would be lost
    a_no_req_in_second: assert property (@(posedge clk_i) disable iff (!rstn_i)
        state_q |-> !request_i);

    // 64-bit ops always complete in the following cycle
    a_done_after_64: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (request_i && !int_32_i) |=> done_tick_o);

endmodule

`default_nettype wire

//--- tb.f
+incdir+tb
design/mul_pkg.sv
design/mul_axil_wr.sv
design/mul_unit.sv
design/mul_axil_rd.sv
design/mul_copro_top.sv
tb/tb_mul_copro.sv

//--- tb/tb_axil_tasks.svh
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

// Ready delay for B and R, zero keeps ready up from the start
function automatic int ready_delay();
    return (bp_max == 0) ? 0 : int'($urandom % (bp_max + 1));
endfunction

// One write, AW and W issued together, returns the B response
task automatic axil_write(input logic [mul_pkg::AXI_AW-1:0] addr,
                          input logic [mul_pkg::AXI_DW-1:0] data,
                          input logic [mul_pkg::AXI_DW/8-1:0] strb,
                          output logic [1:0] rsp);
    int hold;
    hold = ready_delay();
    awvalid <= 1'b1;
    awaddr  <= addr;
    wvalid  <= 1'b1;
    wdata   <= data;
    wstrb   <= strb;
    bready  <= (hold == 0);
    @(posedge clk);
    while (!awready) @(posedge clk);       // Joint ready pulse
    check_eq(wready, 1'b1, "wready not paired with awready");
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    @(posedge clk);
    while (!bvalid) @(posedge clk);
    rsp = bresp;
    repeat (hold) begin                    // B stalled by the host
        @(posedge clk);
        check_eq(bvalid, 1'b1, "bvalid dropped before bready");
        check_eq(bresp, rsp, "bresp changed before bready");
    end
    if (hold != 0) begin
        bready <= 1'b1;
        @(posedge clk);
    end
    bready <= 1'b0;
endtask

// One read, returns R data and response
task automatic axil_read(input logic [mul_pkg::AXI_AW-1:0] addr,
                         output logic [mul_pkg::AXI_DW-1:0] data,
                         output logic [1:0] rsp);
    int hold;
    hold = ready_delay();
    arvalid <= 1'b1;
    araddr  <= addr;
    rready  <= (hold == 0);
    @(posedge clk);
    while (!arready) @(posedge clk);
    arvalid <= 1'b0;
    @(posedge clk);
    while (!rvalid) @(posedge clk);
    data = rdata;
    rsp  = rresp;
    repeat (hold) begin                    // R stalled, payload must hold
        @(posedge clk);
        check_eq(rvalid, 1'b1, "rvalid dropped before rready");
        check_eq(rdata, data, "rdata changed before rready");
        check_eq(rresp, rsp, "rresp changed before rready");
    end
    if (hold != 0) begin
        rready <= 1'b1;
        @(posedge clk);
    end
    rready <= 1'b0;
endtask

`endif

//--- tb/tb_mul_copro.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mul_copro;

    localparam int N_CORNER    = 100;       // 5 x 5 corner pairs x 4 func3
    localparam int N_RAND      = 200;
    localparam int N_WORD      = 50;
    localparam int N_MISC      = 20;        // Flag, bus response and back-pressure ops
    localparam int CYCLE_LIMIT = 40 * (N_CORNER + N_RAND + N_WORD + N_MISC) + 200;

    logic                         clk = 1'b0;
    logic                         rstn;
    logic                         awvalid, wvalid, bready, arvalid, rready;
    logic [mul_pkg::AXI_AW-1:0]   awaddr, araddr;
    logic [mul_pkg::AXI_DW-1:0]   wdata;
    logic [mul_pkg::AXI_DW/8-1:0] wstrb;
    logic                         awready, wready, bvalid, arready, rvalid;
    logic [1:0]                   bresp, rresp;
    logic [mul_pkg::AXI_DW-1:0]   rdata;

    logic [63:0] exp_q [$];                 // Pending checks
    logic [63:0] act_q [$];
    string       msg_q [$];
    logic [63:0] cmp_exp;
    logic [63:0] cmp_act;
    string       cmp_msg;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          bp_max = 0;                // Max ready delay on B and R
    int          seed   = 16711;
    int unsigned rnd;
    logic [63:0] last_prod = '0;            // Expected content of the result register
    logic [63:0] corner [5];
    logic [63:0] op_a, op_b;
    logic [31:0] rd_w, rd_h;
    logic [1:0]  resp;
    logic [2:0]  f3;

    always #10 clk = ~clk;                  // 20 ns period

    mul_copro_top u_dut (
        .clk_i            (clk),
        .rstn_i           (rstn),
        .s_axil_awvalid_i (awvalid),
        .s_axil_awready_o (awready),
        .s_axil_awaddr_i  (awaddr),
        .s_axil_wvalid_i  (wvalid),
        .s_axil_wready_o  (wready),
        .s_axil_wdata_i   (wdata),
        .s_axil_wstrb_i   (wstrb),
        .s_axil_bvalid_o  (bvalid),
        .s_axil_bready_i  (bready),
        .s_axil_bresp_o   (bresp),
        .s_axil_arvalid_i (arvalid),
        .s_axil_arready_o (arready),
        .s_axil_araddr_i  (araddr),
        .s_axil_rvalid_o  (rvalid),
        .s_axil_rready_i  (rready),
        .s_axil_rdata_o   (rdata),
        .s_axil_rresp_o   (rresp)
    );

    // RISC-V M result from plain 128-bit arithmetic
    function automatic logic [63:0] ref_mul(input logic [2:0] fn, input logic word,
                                            input logic [63:0] x, input logic [63:0] y);
        logic [127:0] xs;
        logic [127:0] ys;
        logic [127:0] prod;
        logic [63:0]  w;
        xs   = {{64{x[63] && fn != mul_pkg::FUNC3_MULHU}}, x};   // Signed except MULHU
        ys   = {{64{y[63] && (fn == mul_pkg::FUNC3_MUL || fn == mul_pkg::FUNC3_MULH)}}, y};
        prod = xs * ys;
        w    = {{32{x[31]}}, x[31:0]} * {{32{y[31]}}, y[31:0]};
        if (word) return {{32{w[31]}}, w[31:0]};
        if (fn == mul_pkg::FUNC3_MUL) return prod[63:0];
        return prod[127:64];
    endfunction

    task automatic check_eq(input logic [63:0] act, input logic [63:0] exp, input string msg);
        act_q.push_back(act);
        exp_q.push_back(exp);
        msg_q.push_back(msg);
    endtask

    // Checker, drains whatever the stimulus queued
    always @(posedge clk) begin
        while (exp_q.size() != 0) begin
            cmp_exp = exp_q.pop_front();
            cmp_act = act_q.pop_front();
            cmp_msg = msg_q.pop_front();
            checks++;
            assert (cmp_act === cmp_exp) else begin
                $display("ERR t=%0t %s: expected %h, got %h", $time, cmp_msg, cmp_exp, cmp_act);
                errors++;
            end
        end
    end

`include "tb_axil_tasks.svh"

    task automatic load_operands(input logic [63:0] x, input logic [63:0] y);
        logic [1:0] rsp;
        axil_write(mul_pkg::ADDR_SRC1_LO, x[31:0], 4'hF, rsp);
        check_eq(rsp, mul_pkg::RESP_OKAY, "src1 lo write response");
        axil_write(mul_pkg::ADDR_SRC1_HI, x[63:32], 4'hF, rsp);
        check_eq(rsp, mul_pkg::RESP_OKAY, "src1 hi write response");
        axil_write(mul_pkg::ADDR_SRC2_LO, y[31:0], 4'hF, rsp);
        check_eq(rsp, mul_pkg::RESP_OKAY, "src2 lo write response");
        axil_write(mul_pkg::ADDR_SRC2_HI, y[63:32], 4'hF, rsp);
        check_eq(rsp, mul_pkg::RESP_OKAY, "src2 hi write response");
    endtask

    // Start, poll status, read both halves against the model
    task automatic start_and_check(input logic [2:0] fn, input logic word,
                                   input logic [63:0] x, input logic [63:0] y);
        logic [31:0] ctrl;
        logic [31:0] st;
        logic [31:0] lo;
        logic [31:0] hi;
        logic [1:0]  rsp;
        ctrl = '0;
        ctrl[mul_pkg::CTRL_FUNC3_LSB +: 3] = fn;
        ctrl[mul_pkg::CTRL_WORD_BIT]       = word;
        ctrl[mul_pkg::CTRL_START_BIT]      = 1'b1;
        axil_write(mul_pkg::ADDR_CTRL, ctrl, 4'h1, rsp);       // Byte 0 only
        check_eq(rsp, mul_pkg::RESP_OKAY, "ctrl write response");
        st = '0;
        while (!st[mul_pkg::STAT_DONE_BIT]) begin              // Latency not fixed
            axil_read(mul_pkg::ADDR_STATUS, st, rsp);
            check_eq(rsp, mul_pkg::RESP_OKAY, "status read response");
        end
        axil_read(mul_pkg::ADDR_RES_LO, lo, rsp);
        check_eq(rsp, mul_pkg::RESP_OKAY, "result lo read response");
        axil_read(mul_pkg::ADDR_RES_HI, hi, rsp);
        check_eq(rsp, mul_pkg::RESP_OKAY, "result hi read response");
        last_prod = ref_mul(fn, word, x, y);
        check_eq({hi, lo}, last_prod, $sformatf("f3=%0d w=%0b a=%h b=%h", fn, word, x, y));
    endtask

    task automatic run_op(input logic [2:0] fn, input logic word,
                          input logic [63:0] x, input logic [63:0] y);
        load_operands(x, y);
        start_and_check(fn, word, x, y);
    endtask

    task automatic write_expect_slverr(input logic [mul_pkg::AXI_AW-1:0] addr);
        logic [1:0] rsp;
        axil_write(addr, $urandom, 4'hF, rsp);
        check_eq(rsp, mul_pkg::RESP_SLVERR, $sformatf("write to %h response", addr));
    endtask

    task automatic read_expect_slverr(input logic [mul_pkg::AXI_AW-1:0] addr);
        logic [31:0] d;
        logic [1:0]  rsp;
        axil_read(addr, d, rsp);
        check_eq(rsp, mul_pkg::RESP_SLVERR, $sformatf("read of %h response", addr));
        check_eq(d, 32'd0, $sformatf("read of %h data", addr));
    endtask

    // Run limit
    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the test did not finish within %0d clock cycles", CYCLE_LIMIT);
        $display("Errors: %0d in %0d checks", errors, checks);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        rnd       = $urandom(seed);              // Seeded once
        corner[0] = 64'd0;
        corner[1] = 64'd1;
        corner[2] = '1;                          // -1
        corner[3] = 64'h8000_0000_0000_0000;     // Most negative
        corner[4] = 64'h7FFF_FFFF_FFFF_FFFF;     // Most positive
        awvalid <= 1'b0;
        awaddr  <= '0;
        wvalid  <= 1'b0;
        wdata   <= '0;
        wstrb   <= '0;
        bready  <= 1'b0;
        arvalid <= 1'b0;
        araddr  <= '0;
        rready  <= 1'b0;
        rstn    <= 1'b0;
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);

        axil_read(mul_pkg::ADDR_STATUS, rd_w, resp);
        check_eq(rd_w, 32'd0, "done flag after reset");

        for (int k = 0; k < 4; k++) begin
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    f3 = k[2:0];
                    run_op(f3, 1'b0, corner[i], corner[j]);
                end
            end
        end

        repeat (N_RAND) begin
            op_a = {$urandom, $urandom};
            op_b = {$urandom, $urandom};
            f3   = $urandom % 4;
            run_op(f3, 1'b0, op_a, op_b);
        end

        // MULW, upper halves hold garbage
        repeat (N_WORD) begin
            op_a = {$urandom, $urandom};
            op_b = {$urandom, $urandom};
            run_op(mul_pkg::FUNC3_MUL, 1'b1, op_a, op_b);
        end

        // Read-only offsets refuse writes, result and done stay
        write_expect_slverr(mul_pkg::ADDR_STATUS);
        write_expect_slverr(mul_pkg::ADDR_RES_LO);
        write_expect_slverr(mul_pkg::ADDR_RES_HI);
        axil_read(mul_pkg::ADDR_RES_LO, rd_w, resp);
        axil_read(mul_pkg::ADDR_RES_HI, rd_h, resp);
        check_eq({rd_h, rd_w}, last_prod, "result after refused writes");
        axil_read(mul_pkg::ADDR_STATUS, rd_w, resp);
        check_eq(rd_w, 32'd1, "done flag after refused writes");
        read_expect_slverr(mul_pkg::ADDR_SRC1_LO);
        read_expect_slverr(mul_pkg::ADDR_SRC1_HI);
        read_expect_slverr(mul_pkg::ADDR_SRC2_LO);
        read_expect_slverr(mul_pkg::ADDR_SRC2_HI);
        read_expect_slverr(mul_pkg::ADDR_CTRL);

        // Byte 0 strobe, seen through a multiply by 1
        op_a = {$urandom, $urandom};
        load_operands(op_a, 64'd1);
        rd_w = $urandom;
        axil_write(mul_pkg::ADDR_SRC1_LO, rd_w, 4'b0001, resp);
        check_eq(resp, mul_pkg::RESP_OKAY, "strobed write response");
        op_a[7:0] = rd_w[7:0];
        start_and_check(mul_pkg::FUNC3_MUL, 1'b0, op_a, 64'd1);
        start_and_check(mul_pkg::FUNC3_MULHU, 1'b0, op_a, 64'd1);

        bp_max = 6;                              // Random bready and rready stalls
        repeat (10) begin
            op_a = {$urandom, $urandom};
            op_b = {$urandom, $urandom};
            f3   = $urandom % 4;
            run_op(f3, 1'b0, op_a, op_b);
        end
        bp_max = 0;

        repeat (2) @(posedge clk);               // Let the checker drain
        $display("Errors: %0d in %0d checks", errors, checks);
        if (errors == 0) $display("STATUS: PASS");
        else $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
